/* verilog/sdc_pkg.sv */
`default_nettype none

package sdc_pkg;

	//////////////////////////////
	// command and state encodings
	//////////////////////////////

	// sdram bus command as ras_n cas_n we_n
	typedef enum logic [2:0] {
		cmd_load_mr      = 3'b000,
		cmd_auto_refresh = 3'b001,
		cmd_precharge    = 3'b010,
		cmd_active       = 3'b011,
		cmd_write        = 3'b100,
		cmd_read         = 3'b101,
		cmd_burst_stop   = 3'b110,  // encoded, never issued
		cmd_nop          = 3'b111
	} sdc_cmd_t;

	typedef enum logic [3:0] {
		st_lmreg     = 4'h0,
		st_aref      = 4'h1,
		st_prech     = 4'h2,
		st_wait      = 4'h3,
		st_powerup   = 4'h4,
		st_idle      = 4'h5,
		st_prechwait = 4'hc,
		st_arefwait  = 4'hd
	} ctl_state_t;

	// one access per bank
	typedef enum logic [2:0] {
		bk_idle, bk_act, bk_trcd, bk_col, bk_data, bk_twr, bk_prech, bk_trp
	} bank_state_t;

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int DLY_W        = 4;
	typedef logic [DLY_W-1:0] dly_t;

	localparam int POWERUP_WAIT = 32;                     // short for sim
	localparam int WAIT_W       = $clog2(POWERUP_WAIT);
	localparam int INIT_AREFS   = 2;

	localparam int NUM_BANKS    = 4;
	localparam int BANK_W       = 2;
	localparam int MODE_W       = 12;
	localparam int BL_CODE_W    = 3;                      // mode reg low field
	localparam int BL_W         = 4;
	typedef logic [BL_W-1:0] bl_t;

endpackage

`default_nettype wire

/* verilog/sdc_bank_if.sv */
`timescale 1ns/1ps
`default_nettype none

// arbiter to one bank sequencer
interface sdc_bank_if;
	import sdc_pkg::*;

	logic      sel;       // start pulse
	sdc_cmd_t  cmd;
	logic      busy;
	logic      req_ack;
	logic      write_en;
	logic      read_en;
	logic      row_addr;

	modport arb (
		output sel,
		input  cmd, busy, req_ack, write_en, read_en, row_addr
	);

	modport bank (
		input  sel,
		output cmd, busy, req_ack, write_en, read_en, row_addr
	);

endinterface

`default_nettype wire

/* verilog/sdc_init_ref_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module sdc_init_ref_fsm (
	input  wire logic              clk,
	input  wire logic              rst2,
	input  wire sdc_pkg::dly_t     i_trp_d,
	input  wire sdc_pkg::dly_t     i_trca_d,
	input  wire logic              i_ref_set,
	input  wire logic              i_sdr_req,
	input  wire logic              i_req_ack,
	input  wire logic              i_bus_free,
	input  wire sdc_pkg::sdc_cmd_t i_cmd,       // command on the bus
	output sdc_pkg::sdc_cmd_t      o_ctl_cmd,
	output logic                   o_init_done,
	output logic                   o_ref_pend,
	output logic                   o_mrs_addr,
	output logic                   o_mrow_addr
);
	import sdc_pkg::*;

	ctl_state_t        state, nxt;
	logic [WAIT_W-1:0] wait_cnt;
	dly_t              trp_cnt;
	dly_t              trca_cnt;
	logic [1:0]        aref_cnt;
	logic              trp_end, trca_end;
	logic              ref_req;                   // pulse seen, not yet pending
	logic              pend_go, ref_done;

	assign trp_end  = (state == st_prechwait) && (trp_cnt == i_trp_d);
	assign trca_end = (state == st_arefwait) && (trca_cnt == i_trca_d);
	assign ref_done = trca_end && o_init_done;

	// hold off until the running access is acked
	assign pend_go  = (i_ref_set || ref_req) && (i_req_ack || !i_sdr_req) && !o_ref_pend;

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb
	begin
		nxt = state;
		case (state)
			st_powerup:   nxt = st_wait;
			st_wait:
				if (wait_cnt == WAIT_W'(POWERUP_WAIT - 2))
					nxt = st_prech;
			st_prech:     nxt = st_prechwait;
			st_prechwait:
				if (trp_end)
					nxt = st_aref;        // init and refresh alike
			st_aref:      nxt = st_arefwait;
			st_arefwait:
				if (trca_end)
				begin
					if (o_init_done)
						nxt = st_idle;
					else if (aref_cnt == 2'(INIT_AREFS))
						nxt = st_lmreg;
					else
						nxt = st_aref;
				end
			st_lmreg:     nxt = st_idle;
			st_idle:
				if (o_ref_pend && i_bus_free)
					nxt = st_prech;
			default:      nxt = st_powerup;
		endcase
	end

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			state       <= st_powerup;
			wait_cnt    <= '0;
			trp_cnt     <= '0;
			trca_cnt    <= '0;
			aref_cnt    <= '0;
			o_init_done <= 1'b0;
			ref_req     <= 1'b0;
			o_ref_pend  <= 1'b0;
		end
		else
		begin
			state    <= nxt;
			wait_cnt <= (state == st_wait) ? wait_cnt + 1'b1 : '0;
			trp_cnt  <= (state == st_prechwait) ? trp_cnt + 1'b1 : '0;
			trca_cnt <= (state == st_arefwait) ? trca_cnt + 1'b1 : '0;
			if (state == st_aref && !o_init_done)
				aref_cnt <= aref_cnt + 1'b1;
			if (state == st_lmreg)
				o_init_done <= 1'b1;              // sticky until reset
			ref_req <= (i_ref_set || ref_req) && !pend_go;
			if (ref_done)
				o_ref_pend <= 1'b0;
			else if (pend_go)
				o_ref_pend <= 1'b1;
		end
	end

	always_comb
	begin
		case (state)
			st_prech: o_ctl_cmd = cmd_precharge;   // precharge all
			st_aref:  o_ctl_cmd = cmd_auto_refresh;
			st_lmreg: o_ctl_cmd = cmd_load_mr;
			default:  o_ctl_cmd = cmd_nop;
		endcase
	end

	assign o_mrs_addr  = (state == st_lmreg);
	assign o_mrow_addr = (i_cmd == cmd_precharge);  // bank or all

	// no init or refresh command over a running access
	a_bus_idle: assert property (@(posedge clk) disable iff (!rst2)
		(o_ctl_cmd != cmd_nop) |-> i_bus_free);

endmodule

`default_nettype wire

/* verilog/sdc_bank_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module sdc_bank_seq (
	input  wire logic          clk,
	input  wire logic          rst2,
	input  wire logic          i_wr_n,
	input  wire sdc_pkg::bl_t  i_bl,
	input  wire sdc_pkg::dly_t i_trcd_d,
	input  wire sdc_pkg::dly_t i_twr_d,
	input  wire sdc_pkg::dly_t i_trp_d,
	sdc_bank_if.bank           bank
);
	import sdc_pkg::*;

	bank_state_t state, nxt;
	bank_state_t burst_next;       // where the burst ends up
	dly_t        cnt;              // cycles in current state
	logic        wr_n_q;
	logic        burst_on;

	assign burst_next = wr_n_q ? bk_prech : bk_twr;

	always_comb
	begin
		nxt = state;
		case (state)
			bk_idle:
				if (bank.sel)
					nxt = bk_act;
			bk_act:   nxt = (i_trcd_d == '0) ? bk_col : bk_trcd;
			bk_trcd:
				if (cnt == i_trcd_d - 1'b1)
					nxt = bk_col;
			bk_col:   nxt = (i_bl == BL_W'(1)) ? burst_next : bk_data;
			bk_data:
				if (cnt == i_bl - BL_W'(2))
					nxt = burst_next;
			bk_twr:
				if (cnt == i_twr_d)
					nxt = bk_prech;
			bk_prech: nxt = bk_trp;
			bk_trp:
				if (cnt == i_trp_d)
					nxt = bk_idle;
			default:  nxt = bk_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			state  <= bk_idle;
			cnt    <= '0;
			wr_n_q <= 1'b1;
		end
		else
		begin
			state <= nxt;
			cnt   <= (nxt != state) ? '0 : cnt + 1'b1;
			if (state == bk_idle && bank.sel)
				wr_n_q <= i_wr_n;              // direction for this access
		end
	end

	//////////////////////////////
	// bank outputs
	//////////////////////////////
	assign burst_on      = (state == bk_col) || (state == bk_data);
	assign bank.busy     = (state != bk_idle);
	assign bank.req_ack  = (state == bk_col);
	assign bank.row_addr = (state == bk_act);
	assign bank.write_en = burst_on && !wr_n_q;
	assign bank.read_en  = burst_on && wr_n_q;

	always_comb
	begin
		case (state)
			bk_act:   bank.cmd = cmd_active;
			bk_col:   bank.cmd = wr_n_q ? cmd_read : cmd_write;
			bk_prech: bank.cmd = cmd_precharge;
			default:  bank.cmd = cmd_nop;
		endcase
	end

	// arbiter only starts an idle bank
	a_sel_idle: assert property (@(posedge clk) disable iff (!rst2)
		bank.sel |-> !bank.busy);

endmodule

`default_nettype wire

/* verilog/sdc_bank_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module sdc_bank_arb (
	input  wire logic                       clk,
	input  wire logic                       rst2,
	input  wire logic                       i_sdr_req,
	input  wire logic [sdc_pkg::BANK_W-1:0] i_bnk_adr,
	input  wire logic [sdc_pkg::MODE_W-1:0] i_mode_reg,
	input  wire logic                       i_init_done,
	input  wire logic                       i_ref_pend,
	input  wire sdc_pkg::sdc_cmd_t          i_ctl_cmd,
	sdc_bank_if.arb                         banks [sdc_pkg::NUM_BANKS],
	output logic                            o_bus_free,
	output sdc_pkg::bl_t                    o_bl,
	output sdc_pkg::sdc_cmd_t               o_cmd,
	output logic                            o_req_ack,
	output logic                            o_write_en,
	output logic                            o_read_en,
	output logic                            o_row_addr
);
	import sdc_pkg::*;

	logic                 sel_q;             // one-cycle start
	logic [BANK_W-1:0]    bnk_q;             // bank of current access
	logic                 start;
	logic [BL_CODE_W-1:0] bl_code;
	sdc_cmd_t             bk_cmd [NUM_BANKS];
	logic [NUM_BANKS-1:0] bk_busy, bk_ack, bk_wr, bk_rd, bk_row;

	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		assign banks[i].sel = sel_q && (bnk_q == BANK_W'(i));
		assign bk_cmd[i]    = banks[i].cmd;
		assign bk_busy[i]   = banks[i].busy;
		assign bk_ack[i]    = banks[i].req_ack;
		assign bk_wr[i]     = banks[i].write_en;
		assign bk_rd[i]     = banks[i].read_en;
		assign bk_row[i]    = banks[i].row_addr;
	end

	assign o_bus_free = !(|bk_busy) && !sel_q;
	// no new bank while refresh is pending
	assign start = i_sdr_req && i_init_done && !i_ref_pend && o_bus_free;

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			sel_q <= 1'b0;
			bnk_q <= '0;
		end
		else
		begin
			sel_q <= start;
			if (start)
				bnk_q <= i_bnk_adr;
		end
	end

	//////////////////////////////
	// burst length decode
	//////////////////////////////
	assign bl_code = i_mode_reg[BL_CODE_W-1:0];

	always_comb
	begin
		case (bl_code)
			3'd1:    o_bl = BL_W'(2);
			3'd2:    o_bl = BL_W'(4);
			3'd3:    o_bl = BL_W'(8);
			default: o_bl = BL_W'(1);
		endcase
	end

	// refresh and init own the bus
	assign o_cmd      = (i_init_done && !i_ref_pend) ? bk_cmd[bnk_q] : i_ctl_cmd;
	assign o_req_ack  = bk_ack[bnk_q];
	assign o_write_en = bk_wr[bnk_q];
	assign o_read_en  = bk_rd[bnk_q];
	assign o_row_addr = bk_row[bnk_q];

	a_bl_code: assert property (@(posedge clk) disable iff (!rst2)
		i_init_done |-> (bl_code <= BL_CODE_W'(3)));

endmodule

`default_nettype wire

/* verilog/sdc_bnkctlr.sv */
`timescale 1ns/1ps
`default_nettype none

module sdc_bnkctlr (
	input  wire logic                       clk,
	input  wire logic                       rst2,
	input  wire logic                       i_sdr_req,
	input  wire logic                       i_sdr_req_wr_n,
	input  wire logic [sdc_pkg::BANK_W-1:0] i_bnk_adr,
	input  wire logic [sdc_pkg::MODE_W-1:0] i_mode_reg,
	input  wire logic                       i_ref_set,
	input  wire sdc_pkg::dly_t              i_trp_d,
	input  wire sdc_pkg::dly_t              i_trca_d,
	input  wire sdc_pkg::dly_t              i_trcd_d,
	input  wire sdc_pkg::dly_t              i_twr_d,
	output sdc_pkg::sdc_cmd_t               o_cmd,
	output logic                            o_init_ed,
	output logic                            o_req_ack,
	output logic                            o_write_en,
	output logic                            o_read_en,
	output logic                            o_row_addr,
	output logic                            o_mrs_addr,
	output logic                            o_mrow_addr,
	output sdc_pkg::bl_t                    o_bl
);
	import sdc_pkg::*;

	logic     ref_pend;
	logic     bus_free;
	sdc_cmd_t ctl_cmd;

	sdc_bank_if bank_if [NUM_BANKS] ();

	sdc_init_ref_fsm u_fsm (
		.clk         (clk),
		.rst2        (rst2),
		.i_trp_d     (i_trp_d),
		.i_trca_d    (i_trca_d),
		.i_ref_set   (i_ref_set),
		.i_sdr_req   (i_sdr_req),
		.i_req_ack   (o_req_ack),
		.i_bus_free  (bus_free),
		.i_cmd       (o_cmd),
		.o_ctl_cmd   (ctl_cmd),
		.o_init_done (o_init_ed),
		.o_ref_pend  (ref_pend),
		.o_mrs_addr  (o_mrs_addr),
		.o_mrow_addr (o_mrow_addr)
	);

	sdc_bank_arb u_arb (
		.clk         (clk),
		.rst2        (rst2),
		.i_sdr_req   (i_sdr_req),
		.i_bnk_adr   (i_bnk_adr),
		.i_mode_reg  (i_mode_reg),
		.i_init_done (o_init_ed),
		.i_ref_pend  (ref_pend),
		.i_ctl_cmd   (ctl_cmd),
		.banks       (bank_if),
		.o_bus_free  (bus_free),
		.o_bl        (o_bl),
		.o_cmd       (o_cmd),
		.o_req_ack   (o_req_ack),
		.o_write_en  (o_write_en),
		.o_read_en   (o_read_en),
		.o_row_addr  (o_row_addr)
	);

	// one sequencer per bank
	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		sdc_bank_seq u_seq (
			.clk      (clk),
			.rst2     (rst2),
			.i_wr_n   (i_sdr_req_wr_n),
			.i_bl     (o_bl),
			.i_trcd_d (i_trcd_d),
			.i_twr_d  (i_twr_d),
			.i_trp_d  (i_trp_d),
			.bank     (bank_if[i])
		);
	end

endmodule

`default_nettype wire

/* sim/tb_sdc_bnkctlr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdc_bnkctlr;
	import sdc_pkg::*;

	// fixed timing for the whole run
	localparam dly_t TRP_D  = 4'd2;
	localparam dly_t TRCA_D = 4'd3;
	localparam dly_t TRCD_D = 4'd2;
	localparam dly_t TWR_D  = 4'd1;

	// per-cycle flag bits in the log
	localparam int F_RD   = 0;
	localparam int F_WR   = 1;
	localparam int F_ACK  = 2;
	localparam int F_ROW  = 3;
	localparam int F_MROW = 4;
	localparam int F_MRS  = 5;
	localparam int F_INIT = 6;

	// worst case lengths in cycles
	localparam int INIT_CYC = POWERUP_WAIT + TRP_D + 2 + INIT_AREFS * (TRCA_D + 2) + 6;
	localparam int ACC_CYC  = 3 + TRCD_D + 1 + 8 + TWR_D + 1 + 1 + TRP_D + 1 + 6;
	localparam int REF_CYC  = TRP_D + TRCA_D + 8;
	localparam int NUM_ACC  = 1 + 4 + 1 + 20;
	localparam int LIMIT    = INIT_CYC + REF_CYC + NUM_ACC * ACC_CYC + 100;

	logic              clk;
	logic              rst2;
	logic              i_sdr_req;
	logic              i_sdr_req_wr_n;
	logic [BANK_W-1:0] i_bnk_adr;
	logic [MODE_W-1:0] i_mode_reg;
	logic              i_ref_set;
	sdc_cmd_t          o_cmd;
	logic              o_init_ed, o_req_ack, o_write_en, o_read_en;
	logic              o_row_addr, o_mrs_addr, o_mrow_addr;
	bl_t               o_bl;

	logic [2:0]  cmd_q [$];          // o_cmd per cycle since reset
	logic [6:0]  flg_q [$];
	logic [31:0] lfsr;
	int          cyc_cnt;
	int          last_pre;           // log index of the latest precharge
	int          test_err, total_err, n_ok, n_bad;

	sdc_bnkctlr dut_i (
		.clk            (clk),
		.rst2           (rst2),
		.i_sdr_req      (i_sdr_req),
		.i_sdr_req_wr_n (i_sdr_req_wr_n),
		.i_bnk_adr      (i_bnk_adr),
		.i_mode_reg     (i_mode_reg),
		.i_ref_set      (i_ref_set),
		.i_trp_d        (TRP_D),
		.i_trca_d       (TRCA_D),
		.i_trcd_d       (TRCD_D),
		.i_twr_d        (TWR_D),
		.o_cmd          (o_cmd),
		.o_init_ed      (o_init_ed),
		.o_req_ack      (o_req_ack),
		.o_write_en     (o_write_en),
		.o_read_en      (o_read_en),
		.o_row_addr     (o_row_addr),
		.o_mrs_addr     (o_mrs_addr),
		.o_mrow_addr    (o_mrow_addr),
		.o_bl           (o_bl)
	);

	always #5 clk = ~clk;

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (rst2)
		begin
			cmd_q.push_back(o_cmd);
			flg_q.push_back({o_init_ed, o_mrs_addr, o_mrow_addr, o_row_addr,
				o_req_ack, o_write_en, o_read_en});
		end
	end

	always @(posedge clk)
	begin
		cyc_cnt++;
		if (cyc_cnt > LIMIT)
		begin
			$display("timeout: run still busy after %0d cycles", LIMIT);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[31]};
		end
		return v;
	endfunction

	function automatic logic [2:0] cmd_at(input int i);
		return (i >= 0 && i < cmd_q.size()) ? cmd_q[i] : 3'bxxx;
	endfunction

	function automatic logic flag_at(input int i, input int b);
		return (i >= 0 && i < flg_q.size()) ? flg_q[i][b] : 1'bx;
	endfunction

	task automatic expect_val(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int cyc);
		assert (got === exp)
		else
		begin
			$display("error %s at cycle %0d: got 0x%0h, expected 0x%0h", name, cyc, got, exp);
			test_err++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("problem: %s", what);
			test_err++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_err == 0)
		begin
			n_ok++;
			$display("%-8s ok", name);
		end
		else
		begin
			n_bad++;
			$display("%-8s %0d errors", name, test_err);
		end
		total_err += test_err;
		test_err = 0;
	endtask

	task automatic wait_ack();
		do
			@(negedge clk);
		while (o_req_ack !== 1'b1);
	endtask

	// one access from index s, expected from the timing rules
	task automatic check_access(input int s, input logic wr, input int bl, output int p);
		int a, c, i;
		logic [31:0] exp_cmd;
		logic en;
		a = s;
		while (a < cmd_q.size() && cmd_q[a] == cmd_nop)
			a++;
		expect_true(a == s + 2, "ACTIVE not two cycles after the request");
		expect_true(a > last_pre + TRP_D + 1, "ACTIVE came before the trp wait ended");
		c = a + TRCD_D + 1;
		p = c + bl + (wr ? TWR_D + 1 : 0);
		for (i = s; i <= p; i++)
		begin
			if (i == a)
				exp_cmd = cmd_active;
			else if (i == c)
				exp_cmd = wr ? cmd_write : cmd_read;
			else if (i == p)
				exp_cmd = cmd_precharge;
			else
				exp_cmd = cmd_nop;
			en = (i >= c) && (i < c + bl);
			expect_val("o_cmd", cmd_at(i), exp_cmd, i);
			expect_val("o_row_addr", flag_at(i, F_ROW), i == a, i);
			expect_val("o_req_ack", flag_at(i, F_ACK), i == c, i);
			expect_val("o_write_en", flag_at(i, F_WR), en && wr, i);
			expect_val("o_read_en", flag_at(i, F_RD), en && !wr, i);
			expect_val("o_mrow_addr", flag_at(i, F_MROW), i == p, i);
		end
		last_pre = p;
	endtask

	task automatic do_access(input logic [1:0] bank, input logic wr, input logic [1:0] code);
		int s, p, bl;
		bl = 1 << code;
		@(posedge clk);
		#1;
		i_mode_reg     = {10'h00c, code};
		i_bnk_adr      = bank;
		i_sdr_req_wr_n = !wr;
		i_sdr_req      = 1'b1;
		s = cmd_q.size();
		wait_ack();
		@(posedge clk);
		#1;
		i_sdr_req = 1'b0;
		repeat (bl + TWR_D + TRP_D + 4) @(negedge clk);   // bank back to idle
		check_access(s, wr, bl, p);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_init();
		int i, ar1, ar2, lm;
		logic [31:0] exp_cmd;
		ar1 = POWERUP_WAIT + TRP_D + 2;
		ar2 = ar1 + TRCA_D + 2;
		lm  = ar2 + TRCA_D + 2;
		@(negedge clk);
		expect_val("o_cmd", o_cmd, cmd_nop, -1);
		expect_val("o_init_ed", o_init_ed, 0, -1);
		expect_val("o_req_ack", o_req_ack, 0, -1);
		expect_val("o_write_en", o_write_en, 0, -1);
		expect_val("o_read_en", o_read_en, 0, -1);
		expect_val("o_row_addr", o_row_addr, 0, -1);
		expect_val("o_mrs_addr", o_mrs_addr, 0, -1);
		expect_val("o_mrow_addr", o_mrow_addr, 0, -1);
		repeat (2) @(posedge clk);
		#1;
		rst2      = 1'b1;
		i_sdr_req = 1'b1;                         // held through init, no access yet
		do
			@(negedge clk);
		while (o_mrs_addr !== 1'b1);
		@(posedge clk);
		#1;
		i_sdr_req = 1'b0;
		do
			@(negedge clk);
		while (o_init_ed !== 1'b1);
		repeat (2) @(negedge clk);
		for (i = 0; i <= lm + 1; i++)
		begin
			if (i == POWERUP_WAIT)
				exp_cmd = cmd_precharge;
			else if (i == ar1 || i == ar2)
				exp_cmd = cmd_auto_refresh;
			else if (i == lm)
				exp_cmd = cmd_load_mr;
			else
				exp_cmd = cmd_nop;
			expect_val("o_cmd", cmd_at(i), exp_cmd, i);
			expect_val("o_mrs_addr", flag_at(i, F_MRS), i == lm, i);
			expect_val("o_mrow_addr", flag_at(i, F_MROW), i == POWERUP_WAIT, i);
			expect_val("o_req_ack", flag_at(i, F_ACK), 0, i);
			expect_val("o_init_ed", flag_at(i, F_INIT), i > lm, i);
		end
		last_pre = POWERUP_WAIT;
		end_test("init");
	endtask

	task automatic test_write();
		do_access(2'd2, 1'b1, 2'd2);
		end_test("write");
	endtask

	task automatic test_reads();
		logic [1:0] code;
		for (int k = 0; k < 4; k++)
		begin
			code = 2'(k);
			@(posedge clk);
			#1;
			i_mode_reg = {10'h00c, code};
			@(negedge clk);
			expect_val("o_bl", o_bl, 1 << k, cmd_q.size());
			do_access(code, 1'b0, code);
		end
		end_test("reads");
	endtask

	task automatic test_refresh();
		int r, e, i, p;
		logic [31:0] exp_cmd;
		@(posedge clk);
		#1;
		i_ref_set = 1'b1;
		r = cmd_q.size();
		@(posedge clk);
		#1;
		i_ref_set = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		// request lands inside the trp wait
		i_mode_reg     = {10'h00c, 2'd1};
		i_bnk_adr      = 2'd1;
		i_sdr_req_wr_n = 1'b1;
		i_sdr_req      = 1'b1;
		wait_ack();
		@(posedge clk);
		#1;
		i_sdr_req = 1'b0;
		repeat (2 + TWR_D + TRP_D + 4) @(negedge clk);
		e = r + 5 + TRP_D + TRCA_D;               // last refresh wait cycle
		for (i = r; i <= e; i++)
		begin
			if (i == r + 2)
				exp_cmd = cmd_precharge;
			else if (i == r + 4 + TRP_D)
				exp_cmd = cmd_auto_refresh;
			else
				exp_cmd = cmd_nop;
			expect_val("o_cmd", cmd_at(i), exp_cmd, i);
			expect_val("o_mrow_addr", flag_at(i, F_MROW), i == r + 2, i);
			expect_val("o_req_ack", flag_at(i, F_ACK), 0, i);
		end
		last_pre = r + 2;
		check_access(e + 1, 1'b0, 2, p);
		end_test("refresh");
	endtask

	task automatic test_random();
		logic [1:0] bank, code;
		logic wr;
		for (int n = 0; n < 20; n++)
		begin
			bank = 2'(rand_bits(2));
			wr   = 1'(rand_bits(1));
			code = 2'(rand_bits(2));
			do_access(bank, wr, code);
		end
		end_test("random");
	endtask

	initial
	begin
		clk            = 1'b0;
		rst2           = 1'b0;
		i_sdr_req      = 1'b0;
		i_sdr_req_wr_n = 1'b1;
		i_bnk_adr      = '0;
		i_mode_reg     = {10'h00c, 2'd2};
		i_ref_set      = 1'b0;
		lfsr           = 32'hfc4e_f486;
		cyc_cnt        = 0;
		last_pre       = -100;
		test_err       = 0;
		total_err      = 0;
		n_ok           = 0;
		n_bad          = 0;

		test_init();
		test_write();
		test_reads();
		test_refresh();
		test_random();

		$display("summary: %0d tests, %0d ok, %0d with errors, %0d errors in all",
			n_ok + n_bad, n_ok, n_bad, total_err);
		if (n_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
verilog/sdc_pkg.sv
verilog/sdc_bank_if.sv
verilog/sdc_init_ref_fsm.sv
verilog/sdc_bank_seq.sv
verilog/sdc_bank_arb.sv
verilog/sdc_bnkctlr.sv
sim/tb_sdc_bnkctlr.sv

/* Bender.yml */
package:
  name: sdc_bnkctlr

sources:
  - verilog/sdc_pkg.sv
  - verilog/sdc_bank_if.sv
  - verilog/sdc_init_ref_fsm.sv
  - verilog/sdc_bank_seq.sv
  - verilog/sdc_bank_arb.sv
  - verilog/sdc_bnkctlr.sv
  - target: simulation
    files:
      - sim/tb_sdc_bnkctlr.sv
